//--- filelist.f
+incdir+hw
hw/sram_pkg.sv
hw/ahb_addr_stage.sv
hw/raw_hazard.sv
hw/sram_byte_banks.sv
hw/read_return.sv
hw/ahb_sram_top.sv
bench/ahb_sram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the AHB SRAM testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ahb_sram_tb -f filelist.f -o ahb_sram_sim \
  && ./obj_dir/ahb_sram_sim | tee sim.log \
  && grep -qx "Verification passed" sim.log \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

//--- bench/ahb_sram_tb.sv
// AHB SRAM testbench: pipelined AHB-Lite master driving the DUT against a byte-array model
`timescale 1ns/1ps
`default_nettype none
`include "sram_defines.svh"

module ahb_sram_tb;

  localparam int WAIT_LIMIT = 16;  // edges hready may stay low before the run gives up

  logic                       hclk;
  logic                       hrst_b;
  logic                       hsel;
  logic [1:0]                 htrans;
  logic                       hwrite;
  sram_pkg::hsize_e           hsize;
  logic [`MEM_ADDR_WIDTH-1:0] haddr;
  sram_pkg::hdata_t           hwdata;
  logic                       hready;
  sram_pkg::hdata_t           hrdata;

  logic [7:0] model_mem [1 << `MEM_ADDR_WIDTH];

  // transfer whose data phase is the next one on the bus
  logic                       pend_vld;
  logic                       pend_wr;
  logic [2:0]                 pend_size;
  logic [`MEM_ADDR_WIDTH-1:0] pend_addr;
  sram_pkg::hdata_t           pend_data;
  int                         pend_waits;

  string test_name;
  int    test_checks;
  int    test_errs;
  int    test_count;
  int    total_checks;
  int    total_errs;
  logic  aborted;  // after a timeout the remaining bus steps are skipped

  ahb_sram_top ahb_sram_top_i (
    .hclk   (hclk),
    .hrst_b (hrst_b),
    .hsel   (hsel),
    .htrans (htrans),
    .hwrite (hwrite),
    .hsize  (hsize),
    .haddr  (haddr),
    .hwdata (hwdata),
    .hready (hready),
    .hrdata (hrdata)
  );

  initial
  begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;
  end

  function automatic logic [`LANES-1:0] lanes_of(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                                                 input logic [2:0] size);
    logic [`LANES-1:0] m;
    logic [3:0]        lane;
    m = '0;
    for (int k = 0; k < `LANES; k++)
    begin
      lane = 4'(k);
      m[k] = (size <= 3'd4) && ((lane >> size) == (addr[3:0] >> size));  // same aligned block
    end
    return m;
  endfunction

  function automatic logic [`MEM_ADDR_WIDTH-1:0] aligned(
    input logic [`MEM_ADDR_WIDTH-1:0] addr,
    input logic [2:0]                 size
  );
    logic [`MEM_ADDR_WIDTH-1:0] low;
    low = (`MEM_ADDR_WIDTH'(1) << size) - `MEM_ADDR_WIDTH'(1);
    return addr & ~low;
  endfunction

  function automatic sram_pkg::hdata_t rand_beat();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic check_value(input string what, input sram_pkg::hdata_t exp,
                             input sram_pkg::hdata_t act);
    test_checks++;
    assert (act === exp)
    else
    begin
      test_errs++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errs);
    test_count++;
    total_checks += test_checks;
    total_errs   += test_errs;
  endtask

  // one address phase, together with the data phase of the transfer before it
  task automatic bus_step(input logic act, input logic wr, input logic [2:0] size,
                          input logic [`MEM_ADDR_WIDTH-1:0] addr);
    logic [`LANES-1:0] m;
    sram_pkg::hdata_t  exp;
    sram_pkg::hdata_t  got;
    int                waits;
    int                exp_waits;
    if (aborted)
      return;
    exp_waits = 0;
    // a read right behind a write waits once unless the write beat holds all of its lanes
    if (act && !wr && pend_vld && pend_wr)
    begin
      m = lanes_of(addr, size) & ~lanes_of(pend_addr, pend_size);
      if (addr[`MEM_ADDR_WIDTH-1:4] != pend_addr[`MEM_ADDR_WIDTH-1:4] || m != '0)
        exp_waits = 1;
    end
    hsel   <= act;
    htrans <= act ? 2'b10 : 2'b00;
    hwrite <= wr;
    hsize  <= sram_pkg::hsize_e'(size);
    haddr  <= addr;
    hwdata <= (pend_vld && pend_wr) ? pend_data : rand_beat();
    waits = 0;
    @(posedge hclk);
    while (!hready && waits < WAIT_LIMIT)
    begin
      waits++;
      @(posedge hclk);
    end
    if (!hready)
    begin
      $display("timeout: hready stayed low for %0d cycles in test %s", WAIT_LIMIT, test_name);
      test_errs++;
      aborted = 1'b1;
      return;
    end
    if (pend_vld)
    begin
      m   = lanes_of(pend_addr, pend_size);
      exp = '0;
      got = '0;
      for (int k = 0; k < `LANES; k++)
      begin
        if (m[k])
        begin
          if (pend_wr)
            model_mem[{pend_addr[`MEM_ADDR_WIDTH-1:4], 4'(k)}] = pend_data[8*k +: 8];
          exp[8*k +: 8] = model_mem[{pend_addr[`MEM_ADDR_WIDTH-1:4], 4'(k)}];
          got[8*k +: 8] = hrdata[8*k +: 8];
        end
      end
      check_value($sformatf("wait states at %0h", pend_addr),
                  sram_pkg::hdata_t'(pend_waits), sram_pkg::hdata_t'(waits));
      if (!pend_wr)
        check_value($sformatf("read %0h size %0d", pend_addr, pend_size), exp, got);
    end
    pend_vld   = act;
    pend_wr    = wr;
    pend_size  = size;
    pend_addr  = addr;
    pend_data  = rand_beat();
    pend_waits = exp_waits;
  endtask

  task automatic write_then_read(input logic [2:0] ws, input logic [2:0] rs, input logic far);
    logic [31:0]                rnd;
    logic [3:0]                 wblk;
    logic [`MEM_ADDR_WIDTH-1:0] w;
    logic [`MEM_ADDR_WIDTH-1:0] r;
    rnd  = $urandom;
    w    = aligned(rnd[`MEM_ADDR_WIDTH-1:0], ws);
    wblk = 4'((5'd1 << ws) - 5'd1);
    // the read lands inside the written block, or on another line when far is set
    if (far)
      r = aligned({~w[`MEM_ADDR_WIDTH-1:4], rnd[15:12]}, rs);
    else
      r = aligned({w[`MEM_ADDR_WIDTH-1:4], w[3:0] | (rnd[19:16] & wblk)}, rs);
    bus_step(1'b1, 1'b1, ws, w);
    bus_step(1'b1, 1'b0, rs, r);
    bus_step(1'b1, 1'b0, 3'd4, aligned(r, 3'd4));
    bus_step(1'b0, 1'b0, 3'd0, '0);
  endtask

  task automatic test_reset();
    logic [31:0]                 rnd;
    logic [`LINE_ADDR_WIDTH-1:0] line;
    int                          waited;
    start_test("reset");
    @(posedge hclk);
    hrst_b <= 1'b0;
    repeat (3)
    begin
      @(posedge hclk);
      check_value("hready in reset", '0, sram_pkg::hdata_t'(hready));
    end
    hrst_b <= 1'b1;
    waited = 0;
    @(posedge hclk);
    while (!hready && waited < WAIT_LIMIT)
    begin
      waited++;
      @(posedge hclk);
    end
    if (!hready)
    begin
      $display("timeout: hready did not rise after reset release");
      test_errs++;
      aborted = 1'b1;
    end
    for (int i = 0; i < `SRAM_LINES; i++)
    begin
      line = i[`LINE_ADDR_WIDTH-1:0];
      bus_step(1'b1, 1'b1, 3'd4, {line, 4'h0});  // every line gets a known quadword
    end
    bus_step(1'b0, 1'b0, 3'd0, '0);
    repeat (16)
    begin
      rnd  = $urandom;
      line = rnd[`LINE_ADDR_WIDTH-1:0];
      bus_step(1'b1, 1'b0, 3'd4, {line, 4'h0});
    end
    bus_step(1'b0, 1'b0, 3'd0, '0);
    end_test();
  endtask

  task automatic test_narrow();
    logic [31:0]                 rnd;
    logic [`LINE_ADDR_WIDTH-1:0] line;
    start_test("narrow");
    repeat (4)
    begin
      rnd  = $urandom;
      line = rnd[`LINE_ADDR_WIDTH-1:0];
      for (int s = 0; s < 4; s++)
      begin
        rnd = $urandom;
        bus_step(1'b1, 1'b1, 3'(s), aligned({line, rnd[3:0]}, 3'(s)));
      end
      bus_step(1'b0, 1'b0, 3'd0, '0);
      bus_step(1'b1, 1'b0, 3'd4, {line, 4'h0});
      bus_step(1'b0, 1'b0, 3'd0, '0);
    end
    end_test();
  endtask

  task automatic test_random();
    logic [31:0]                rnd;
    logic [2:0]                 size;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    start_test("random");
    for (int i = 0; i < 200; i++)
    begin
      rnd  = $urandom;
      size = rnd[4:2] % 3'd5;
      addr = rnd[`MEM_ADDR_WIDTH+7:8];
      if (rnd[5])
        addr[`MEM_ADDR_WIDTH-1:6] = '0;  // half the traffic shares four lines
      if (rnd[1:0] == 2'b00)
        bus_step(1'b0, 1'b0, 3'd0, '0);
      bus_step(1'b1, rnd[6], size, aligned(addr, size));
    end
    bus_step(1'b0, 1'b0, 3'd0, '0);
    end_test();
  endtask

  initial
  begin
    void'($urandom(32'h7462));
    hrst_b <= 1'b1;
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwrite <= 1'b0;
    hsize  <= sram_pkg::SIZE_BYTE;
    haddr  <= '0;
    hwdata <= '0;
    pend_vld     = 1'b0;
    pend_wr      = 1'b0;
    pend_waits   = 0;
    test_count   = 0;
    total_checks = 0;
    total_errs   = 0;
    aborted      = 1'b0;
    test_reset();
    test_narrow();
    start_test("bypass");
    repeat (2)
    begin
      write_then_read(3'd4, 3'd2, 1'b0);
      write_then_read(3'd3, 3'd0, 1'b0);
      write_then_read(3'd2, 3'd1, 1'b0);
      write_then_read(3'd4, 3'd4, 1'b0);
    end
    end_test();
    start_test("stall");
    repeat (2)
    begin
      write_then_read(3'd0, 3'd4, 1'b0);
      write_then_read(3'd4, 3'd2, 1'b1);
      write_then_read(3'd2, 3'd3, 1'b0);
      write_then_read(3'd1, 3'd2, 1'b0);
    end
    end_test();
    test_random();
    $display("%0d tests, %0d checks, %0d errors", test_count, total_checks, total_errs);
    if (total_errs == 0 && !aborted)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/ahb_sram_top.sv
// AHB-Lite SRAM slave with a 128-bit data bus and read-after-write forwarding
`timescale 1ns/1ps
`default_nettype none
`include "sram_defines.svh"

module ahb_sram_top (
  input  wire                          hclk,
  input  wire                          hrst_b,
  input  wire                          hsel,
  input  wire [1:0]                    htrans,
  input  wire                          hwrite,
  input  wire sram_pkg::hsize_e        hsize,
  input  wire [`MEM_ADDR_WIDTH-1:0]    haddr,
  input  wire sram_pkg::hdata_t        hwdata,
  output logic                         hready,
  output sram_pkg::hdata_t             hrdata
);

  sram_pkg::ahb_req_t             cur_req;
  sram_pkg::ahb_req_t             wr_req;
  logic                           bypass;
  logic [`LINE_ADDR_WIDTH-1:0]    bank_index;
  sram_pkg::lane_mask_t           bank_wen;
  sram_pkg::hdata_t               bank_wdata;
  sram_pkg::hdata_t               bank_rdata;

  ahb_addr_stage ahb_addr_stage_i (
    .hclk       (hclk),
    .hrst_b     (hrst_b),
    .hsel       (hsel),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .hready     (hready),
    .cur_req    (cur_req),
    .wr_req     (wr_req),
    .bank_index (bank_index),
    .bank_wen   (bank_wen),
    .bank_wdata (bank_wdata)
  );

  raw_hazard raw_hazard_i (
    .hclk    (hclk),
    .hrst_b  (hrst_b),
    .cur_req (cur_req),
    .wr_req  (wr_req),
    .hready  (hready),
    .bypass  (bypass)
  );

  sram_byte_banks sram_byte_banks_i (
    .hclk  (hclk),
    .index (bank_index),
    .wen   (bank_wen),
    .wdata (bank_wdata),
    .rdata (bank_rdata)
  );

  read_return read_return_i (
    .hclk       (hclk),
    .hrst_b     (hrst_b),
    .bypass     (bypass),
    .hwdata     (hwdata),
    .bank_rdata (bank_rdata),
    .hrdata     (hrdata)
  );

endmodule

`default_nettype wire

//--- hw/read_return.sv
// read data return: forwarded write beat or bank output onto hrdata
`timescale 1ns/1ps
`default_nettype none

module read_return (
  input  wire                     hclk,
  input  wire                     hrst_b,
  input  wire                     bypass,
  input  wire sram_pkg::hdata_t   hwdata,
  input  wire sram_pkg::hdata_t   bank_rdata,
  output sram_pkg::hdata_t        hrdata
);

  sram_pkg::hdata_t byp_data;
  logic             byp_vld;

  // flag covers exactly the data phase of the forwarded read
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
    begin
      byp_vld <= 1'b0;
    end
    else
    begin
      byp_vld <= bypass;
    end
  end

  always_ff @(posedge hclk)
  begin
    if (bypass)
    begin
      byp_data <= hwdata;  // whole beat, lanes already sit at their address
    end
  end

  assign hrdata = byp_vld ? byp_data : bank_rdata;

endmodule

`default_nettype wire

//--- hw/sram_byte_banks.sv
// sixteen byte-wide synchronous RAM banks, one per lane of the 128-bit bus
`timescale 1ns/1ps
`default_nettype none
`include "sram_defines.svh"

module sram_byte_banks (
  input  wire                          hclk,
  input  wire [`LINE_ADDR_WIDTH-1:0]   index,
  input  wire [`LANES-1:0]             wen,
  input  wire [`HDATA_WIDTH-1:0]       wdata,
  output wire [`HDATA_WIDTH-1:0]       rdata
);

  for (genvar k = 0; k < `LANES; k++)
  begin : g_lane
    logic [7:0] mem [`SRAM_LINES];
    logic [7:0] rd_byte;

    always_ff @(posedge hclk)
    begin
      if (wen[k])
      begin
        mem[index] <= wdata[8*k +: 8];
      end
      rd_byte <= mem[index];  // old byte when the same line is written
    end

    assign rdata[8*k +: 8] = rd_byte;
  end

endmodule

`default_nettype wire

//--- hw/raw_hazard.sv
// read-after-write check between a read address phase and a write data phase
`timescale 1ns/1ps
`default_nettype none
`include "sram_defines.svh"

module raw_hazard (
  input  wire                      hclk,
  input  wire                      hrst_b,
  input  wire sram_pkg::ahb_req_t  cur_req,
  input  wire sram_pkg::ahb_req_t  wr_req,
  output logic                     hready,
  output logic                     bypass
);

  sram_pkg::lane_mask_t rd_mask;
  sram_pkg::lane_mask_t wr_mask;
  logic                 conflict;
  logic                 same_line;

  // the banks are busy with the write, so the read cannot use them this cycle
  assign conflict = cur_req.valid && !cur_req.write && wr_req.valid;

  assign rd_mask   = sram_pkg::lane_mask(cur_req.addr, cur_req.size);
  assign wr_mask   = sram_pkg::lane_mask(wr_req.addr, wr_req.size);
  assign same_line = cur_req.addr[`MEM_ADDR_WIDTH-1:4] == wr_req.addr[`MEM_ADDR_WIDTH-1:4];

  // every lane the read needs comes from the write beat itself
  assign bypass = conflict && same_line && ((rd_mask & ~wr_mask) == '0);

  // otherwise one wait state lets the read go to the banks after the write lands
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
    begin
      hready <= 1'b0;
    end
    else
    begin
      hready <= !(conflict && !bypass);
    end
  end

endmodule

`default_nettype wire

//--- hw/ahb_addr_stage.sv
// AHB-Lite address phase decode with the data-phase register and the bank control
`timescale 1ns/1ps
`default_nettype none
`include "sram_defines.svh"

module ahb_addr_stage (
  input  wire                              hclk,
  input  wire                              hrst_b,
  input  wire                              hsel,
  input  wire [1:0]                        htrans,
  input  wire                              hwrite,
  input  wire sram_pkg::hsize_e            hsize,
  input  wire [`MEM_ADDR_WIDTH-1:0]        haddr,
  input  wire sram_pkg::hdata_t            hwdata,
  input  wire                              hready,
  output sram_pkg::ahb_req_t               cur_req,
  output sram_pkg::ahb_req_t               wr_req,
  output logic [`LINE_ADDR_WIDTH-1:0]      bank_index,
  output sram_pkg::lane_mask_t             bank_wen,
  output sram_pkg::hdata_t                 bank_wdata
);

  sram_pkg::ahb_req_t dp_req;  // transfer now in its data phase
  logic               accept;

  assign accept = hsel && hready && htrans[1];  // htrans[1] set for NONSEQ and SEQ

  always_comb
  begin
    cur_req.valid = accept;
    cur_req.write = hwrite;
    cur_req.size  = hsize;
    cur_req.addr  = haddr;
  end

  // advances on every completed cycle and holds through a wait state,
  // so a stalled read keeps its address here
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
    begin
      dp_req <= '0;
    end
    else if (hready)
    begin
      dp_req <= cur_req;  // an idle cycle loads an invalid request
    end
  end

  always_comb
  begin
    wr_req       = dp_req;
    wr_req.valid = dp_req.valid && dp_req.write;
  end

  // lane enables line up with the write data in the data phase
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
    begin
      bank_wen <= '0;
    end
    else if (accept && hwrite)
    begin
      bank_wen <= sram_pkg::lane_mask(haddr, hsize);
    end
    else
    begin
      bank_wen <= '0;
    end
  end

  // a write in its data phase and a stalled read both sit in the data-phase register
  always_comb
  begin
    if (wr_req.valid || !hready)
      bank_index = dp_req.addr[`MEM_ADDR_WIDTH-1:4];
    else
      bank_index = haddr[`MEM_ADDR_WIDTH-1:4];
  end

  assign bank_wdata = hwdata;

endmodule

`default_nettype wire

//--- hw/sram_pkg.sv
// SRAM controller types: AHB size codes, transfer request and byte lane decode
`default_nettype none
`include "sram_defines.svh"

package sram_pkg;

  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HWORD = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011,
    SIZE_QWORD = 3'b100
  } hsize_e;

  typedef logic [`LANES-1:0] lane_mask_t;
  typedef logic [`HDATA_WIDTH-1:0] hdata_t;

  typedef struct packed {
    logic                       valid;  // accepted NONSEQ or SEQ
    logic                       write;
    hsize_e                     size;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
  } ahb_req_t;

  // lanes are fixed by address, so a narrow transfer sits at its natural offset
  function automatic lane_mask_t lane_mask(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                                           input hsize_e size);
    lane_mask_t mask;
    case (size)
      SIZE_BYTE:  mask = lane_mask_t'(16'h0001) << addr[3:0];
      SIZE_HWORD: mask = lane_mask_t'(16'h0003) << {addr[3:1], 1'b0};
      SIZE_WORD:  mask = lane_mask_t'(16'h000f) << {addr[3:2], 2'b00};
      SIZE_DWORD: mask = lane_mask_t'(16'h00ff) << {addr[3], 3'b000};
      SIZE_QWORD: mask = '1;
      default:    mask = '0;  // wider than the bus, nothing is touched
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- hw/sram_defines.svh
// SRAM controller geometry: bus width, byte lanes and memory depth
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// one AHB beat covers a full 16-byte line
`define HDATA_WIDTH 128

// one byte-wide bank per lane
`define LANES 16

// byte address bits kept from haddr
`define MEM_ADDR_WIDTH 12

// bank index drops the byte offset within a line
`define LINE_ADDR_WIDTH (`MEM_ADDR_WIDTH - 4)

// lines in every bank
`define SRAM_LINES (1 << `LINE_ADDR_WIDTH)

`endif
